//--- common/palette_pkg.sv
// shared widths, vector types and the download beat format for the palette stage
// import with palette_pkg::* in the module header where needed
`default_nettype none

package palette_pkg;

    localparam int CODE_W  = 8;             // pixel code, lookup prom address
    localparam int PAL_W   = 8;             // palette index, colour prom address
    localparam int COLOR_W = 8;             // rgb332
    localparam int DL_DW   = 8;             // download bytes

    typedef logic [CODE_W-1:0]  code_t;
    typedef logic [PAL_W-1:0]   pal_idx_t;
    typedef logic [COLOR_W-1:0] color_t;
    typedef logic [DL_DW-1:0]   dl_data_t;
    typedef logic [CODE_W:0]    dl_addr_t;  // msb picks the region

    // region map, top address bit of a download beat
    localparam int   DL_REGION_BIT = CODE_W;
    localparam logic REGION_LUT    = 1'b0;  // 0x000..0x0ff
    localparam logic REGION_COL    = 1'b1;  // 0x100..0x1ff

    // one download beat, 17 bits
    typedef struct packed {
        dl_addr_t addr;
        dl_data_t data;
    } dl_beat_t;

    // download session FSM
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        DRAIN
    } dl_state_t;

endpackage

`default_nettype wire

//--- rtl/prom.sv
// loadable prom, one array with separate read and write addresses
// read is synchronous and only advances with cen
// writes ignore cen so a download can go on while reads are stalled
`timescale 1ns/1ps
`default_nettype none

module prom #(
    parameter int AW = 8,
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          cen,      // read enable
    input  logic [DW-1:0] data,
    input  logic [AW-1:0] rd_addr,
    input  logic [AW-1:0] wr_addr,
    input  logic          we,
    output logic [DW-1:0] q
);

    // contents come only from downloads, no init
    logic [DW-1:0] mem [2**AW];

    // read port, q holds while cen is low
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];          // registered read
        end
    end

    // write port, not gated by cen
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    // read and write at the same address in one cycle
    // returns the old word on q

endmodule

`default_nettype wire

//--- download/dl_ctrl.sv
// download controller for the two palette proms
// buffers beats against the credits the source holds, drains one per cycle
// into lut or colour prom by the region bit, and returns a credit per write
// holds lookup_en low during a dl_start session and until the buffer drains
`timescale 1ns/1ps
`default_nettype none

module dl_ctrl
    import palette_pkg::*;
#(
    parameter int DL_CREDITS = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     dl_start,          // session level
    input  logic     dl_valid,
    input  dl_beat_t dl_beat,
    output logic     dl_credit,         // one pulse per prom write
    output logic     lut_we,
    output logic     col_we,
    output pal_idx_t wr_addr,
    output dl_data_t wr_data,
    output logic     lookup_en
);

    localparam int PW = (DL_CREDITS > 1) ? $clog2(DL_CREDITS) : 1;
    localparam int CW = $clog2(DL_CREDITS + 1);

    dl_beat_t      beat_buf [DL_CREDITS];   // circular buffer
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] buf_cnt;                 // beats waiting
    logic          push;
    logic          pop;
    dl_beat_t      head;
    dl_state_t     state;

    assign push = dl_valid;                 // source only sends on credit
    assign pop  = (buf_cnt != '0);          // drain every cycle
    assign head = beat_buf[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            beat_buf[wr_ptr] <= dl_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            buf_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DL_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DL_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            buf_cnt <= buf_cnt + CW'(push) - CW'(pop);
        end
    end

    // registered write stage, credit goes back in the write cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            lut_we    <= 1'b0;
            col_we    <= 1'b0;
            dl_credit <= 1'b0;
        end else begin
            lut_we    <= pop && (head.addr[DL_REGION_BIT] == REGION_LUT);
            col_we    <= pop && (head.addr[DL_REGION_BIT] == REGION_COL);
            dl_credit <= pop;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (pop) begin
            wr_addr <= head.addr[CODE_W-1:0];   // region bit dropped
            wr_data <= head.data;
        end
    end

    // session FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            lookup_en <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (dl_start) begin
                        state     <= LOAD;
                        lookup_en <= 1'b0;  // block lookups for the session
                    end
                end
                LOAD: begin
                    if (!dl_start) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (dl_start) begin
                        state <= LOAD;      // new session before drain ended
                    end else if (buf_cnt == '0 && !dl_valid) begin
                        state     <= IDLE;  // last write is in flight now
                        lookup_en <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/pal_lookup.sv
// two stage palette lookup, code -> lut prom -> colour prom -> out_color
// input pixels wait in a small holding queue sized by PIX_CREDITS
// a pixel starts only when the sink has granted a slot for it, so the
// pipe never stalls once started; out_valid comes 2 cycles after accept
`timescale 1ns/1ps
`default_nettype none

module pal_lookup
    import palette_pkg::*;
#(
    parameter int PIX_CREDITS = 2
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   lookup_en,
    input  logic   pix_valid,
    input  code_t  pix_code,
    output logic   pix_credit,
    input  logic   out_credit,          // sink grants one slot
    output code_t  lut_addr,
    input  color_t col_q,
    output logic   rd_en,               // cen of both proms
    output logic   out_valid,
    output color_t out_color
);

    localparam int PW  = (PIX_CREDITS > 1) ? $clog2(PIX_CREDITS) : 1;
    localparam int QW  = $clog2(PIX_CREDITS + 1);
    localparam int OCW = 10;            // output credit counter

    code_t          hold_mem [PIX_CREDITS];
    logic [PW-1:0]  hold_wr;
    logic [PW-1:0]  hold_rd;
    logic [QW-1:0]  hold_cnt;
    logic [OCW-1:0] out_cred;           // granted, not yet used by out_valid
    logic [1:0]     vld;                // [0] lut read done, [1] colour read done
    logic [1:0]     in_flight;
    logic           accept;

    assign in_flight = {1'b0, vld[0]} + {1'b0, vld[1]};
    // each pixel in flight already holds one of the counted credits
    assign accept    = lookup_en && (hold_cnt != '0) && (out_cred > OCW'(in_flight));
    assign lut_addr  = hold_mem[hold_rd];
    assign rd_en     = accept || (vld != 2'b00);
    assign out_valid = vld[1];
    assign out_color = col_q;           // colour prom output straight out

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            hold_mem[hold_wr] <= pix_code;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_wr    <= '0;
            hold_rd    <= '0;
            hold_cnt   <= '0;
            out_cred   <= '0;
            vld        <= 2'b00;
            pix_credit <= 1'b0;
        end else begin
            if (pix_valid) begin
                hold_wr <= (hold_wr == PW'(PIX_CREDITS - 1)) ? '0 : hold_wr + 1'b1;
            end
            if (accept) begin
                hold_rd <= (hold_rd == PW'(PIX_CREDITS - 1)) ? '0 : hold_rd + 1'b1;
            end
            hold_cnt   <= hold_cnt + QW'(pix_valid) - QW'(accept);
            out_cred   <= out_cred + OCW'(out_credit) - OCW'(out_valid);
            vld        <= {vld[0], accept};
            pix_credit <= accept;       // slot freed in the holding queue
        end
    end

endmodule

`default_nettype wire

//--- rtl/palette_top.sv
// palette stage top level
// byte download fills the lookup and colour proms, pixel codes are
// mapped to rgb332 colours; all ports use credit flow control
`timescale 1ns/1ps
`default_nettype none

module palette_top
    import palette_pkg::*;
#(
    parameter int DL_CREDITS  = 4,
    parameter int PIX_CREDITS = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     dl_start,
    input  logic     dl_valid,
    input  dl_beat_t dl_beat,
    output logic     dl_credit,
    input  logic     pix_valid,
    input  code_t    pix_code,
    output logic     pix_credit,
    input  logic     out_credit,
    output logic     out_valid,
    output color_t   out_color
);

    logic     lut_we;
    logic     col_we;
    pal_idx_t wr_addr;
    dl_data_t wr_data;
    logic     lookup_en;
    code_t    lut_addr;
    pal_idx_t lut_q;        // also the colour prom read address
    color_t   col_q;
    logic     rd_en;

    dl_ctrl #(
        .DL_CREDITS (DL_CREDITS)
    ) i_dl_ctrl (
        .clk       (clk),
        .reset     (reset),
        .dl_start  (dl_start),
        .dl_valid  (dl_valid),
        .dl_beat   (dl_beat),
        .dl_credit (dl_credit),
        .lut_we    (lut_we),
        .col_we    (col_we),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .lookup_en (lookup_en)
    );

    pal_lookup #(
        .PIX_CREDITS (PIX_CREDITS)
    ) i_pal_lookup (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_en),
        .pix_valid  (pix_valid),
        .pix_code   (pix_code),
        .pix_credit (pix_credit),
        .out_credit (out_credit),
        .lut_addr   (lut_addr),
        .col_q      (col_q),
        .rd_en      (rd_en),
        .out_valid  (out_valid),
        .out_color  (out_color)
    );

    prom #(.AW(CODE_W), .DW(PAL_W)) lut_prom (
        .clk     (clk),
        .cen     (rd_en),
        .data    (wr_data),
        .rd_addr (lut_addr),
        .wr_addr (wr_addr),
        .we      (lut_we),
        .q       (lut_q)
    );

    prom #(.AW(PAL_W), .DW(COLOR_W)) col_prom (
        .clk     (clk),
        .cen     (rd_en),
        .data    (wr_data),
        .rd_addr (lut_q),
        .wr_addr (wr_addr),
        .we      (col_we),
        .q       (col_q)
    );

endmodule

`default_nettype wire

//--- tests/palette_top_asserts.sv
// concurrent checks on the palette stage, bound into pal_lookup and dl_ctrl
// ports a binding does not use are tied off at the bind
`timescale 1ns/1ps
`default_nettype none

module palette_top_asserts #(
    parameter int MAX_CNT = 4
) (
    input wire       clk,
    input wire       reset,
    input wire       accept,
    input wire       out_valid,
    input wire [9:0] out_cred,
    input wire       lut_we,
    input wire       col_we,
    input wire       lookup_en,
    input wire [7:0] buf_cnt
);

    // pipe is exactly two stages deep, and the pixel still holds its granted slot
    a_out_after_accept: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> ($past(accept, 2) && out_cred != '0))
        else $error("out_valid without an accept two cycles earlier or without a credit");

    // one region per download beat, and prom writes only while lookups are blocked
    a_one_we: assert property (@(posedge clk) disable iff (reset)
        (lut_we || col_we) |-> (!(lut_we && col_we) && !lookup_en))
        else $error("prom write with both regions or while lookups are enabled");

    a_buf_bound: assert property (@(posedge clk) disable iff (reset)
        buf_cnt <= 8'(MAX_CNT))
        else $error("download buffer count above its depth");

endmodule

`default_nettype wire

//--- tests/tb_palette_top.sv
// testbench for palette_top, drives download and pixel ports under credit rules
// shadow proms model expected colours, a compare process checks each out_valid
`timescale 1ns/1ps
`default_nettype none

module tb_palette_top;
    import palette_pkg::*;

    localparam int DL_CREDITS  = 4;
    localparam int PIX_CREDITS = 2;
    localparam int N_BEATS     = 512 + 32;          // full plus partial download
    localparam int N_PIXELS    = 1 + 256 + 20 + 8;
    localparam int LIMIT       = (N_BEATS + N_PIXELS) * 4 + 200;

    logic clk, reset, dl_start, dl_valid, pix_valid, out_credit;
    dl_beat_t dl_beat;
    code_t pix_code;
    logic dl_credit, pix_credit, out_valid;
    color_t out_color;

    logic [7:0] lut_shadow [256];   // model of lookup prom
    logic [7:0] col_shadow [256];   // model of colour prom
    color_t exp_q [$];
    string current_test = "reset";
    int beats_sent = 0, dl_pulses = 0, pix_sent = 0, pix_pulses = 0;
    int out_cnt = 0, granted = 0, grant_pending = 0, cycles = 0;
    int checks = 0, errors = 0, tests_run = 0, tests_failed = 0;
    bit dl_busy = 0;

    palette_top #(.DL_CREDITS(DL_CREDITS), .PIX_CREDITS(PIX_CREDITS)) i_palette_top (
        .clk(clk), .reset(reset), .dl_start(dl_start), .dl_valid(dl_valid),
        .dl_beat(dl_beat), .dl_credit(dl_credit), .pix_valid(pix_valid),
        .pix_code(pix_code), .pix_credit(pix_credit), .out_credit(out_credit),
        .out_valid(out_valid), .out_color(out_color)
    );

    bind pal_lookup palette_top_asserts #(.MAX_CNT(4)) i_lookup_asserts (
        .clk(clk), .reset(reset), .accept(accept), .out_valid(out_valid),
        .out_cred(out_cred), .lut_we(1'b0), .col_we(1'b0), .lookup_en(1'b0),
        .buf_cnt(8'd0));
    bind dl_ctrl palette_top_asserts #(.MAX_CNT(DL_CREDITS)) i_dl_asserts (
        .clk(clk), .reset(reset), .accept(1'b0), .out_valid(1'b0),
        .out_cred(10'd0), .lut_we(lut_we), .col_we(col_we), .lookup_en(lookup_en),
        .buf_cnt({5'b0, buf_cnt}));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns
    end

    // reference, code -> palette index -> colour
    function automatic color_t expected_color(input code_t code);
        return col_shadow[lut_shadow[code]];
    endfunction

    // region bit picks the shadow prom
    function automatic void load_shadow(input dl_addr_t addr, input dl_data_t data);
        if (addr[DL_REGION_BIT] == REGION_COL) col_shadow[addr[7:0]] = data;
        else lut_shadow[addr[7:0]] = data;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s expected %h actual %h", current_test, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("ERROR in %s: %s", current_test, msg);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                         // drive phase
    endtask

    task automatic send_beat(input dl_addr_t addr, input dl_data_t data);
        while (DL_CREDITS - beats_sent + dl_pulses <= 0) next_cycle();
        dl_valid     = 1'b1;
        dl_beat.addr = addr;
        dl_beat.data = data;
        beats_sent++;
        next_cycle();
        dl_valid = 1'b0;
    endtask

    task automatic send_pixel(input code_t code);
        while (PIX_CREDITS - pix_sent + pix_pulses <= 0) next_cycle();
        pix_valid = 1'b1;
        pix_code  = code;
        exp_q.push_back(expected_color(code));
        pix_sent++;
        next_cycle();
        pix_valid = 1'b0;
    endtask

    task automatic grant_out_credits(input int n);
        grant_pending += n;         // the credit driver pays these out one per cycle
    endtask

    task automatic wait_for_outputs();
        while (out_cnt < pix_sent) next_cycle();
    endtask

    task automatic wait_for_dl_credits();
        while (dl_pulses < beats_sent) next_cycle();
    endtask

    task automatic end_test(input int errors_before);
        tests_run++;
        if (errors != errors_before) tests_failed++;
        $display("test %-16s %s", current_test, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    // out_credit driver
    initial begin
        bit pay;
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            pay = (grant_pending > 0);  // one grant per cycle
            if (pay) grant_pending--;
            #2;
            out_credit = pay;
        end
    end

    // counters and credit bookkeeping
    always @(posedge clk) begin
        if (!reset) begin
            // beats on the bus against credits returned before this edge
            if (dl_valid && beats_sent - dl_pulses > DL_CREDITS)
                report_failure("download source spent a credit it did not hold");
            if (pix_valid && pix_sent - pix_pulses > PIX_CREDITS)
                report_failure("pixel source spent a credit it did not hold");
            if (dl_credit) dl_pulses++;
            if (pix_credit) pix_pulses++;
            if (dl_pulses > beats_sent) report_failure("more download credits than beats");
            if (pix_pulses > pix_sent) report_failure("more pixel credits than pixels");
            if (out_valid && dl_busy) report_failure("output appeared during a download");
        end
    end

    // compare process
    always @(posedge clk) begin
        if (!reset && out_valid) begin
            out_cnt++;
            if (out_cnt > granted) report_failure("more outputs than output credits");
            if (exp_q.size() == 0) report_failure("output with no pixel pending");
            else check_value("out_color", exp_q.pop_front(), out_color);
        end
        if (!reset && out_credit) granted++;    // usable from the next edge on
    end

    // timeout
    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles in %s", cycles, current_test);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int e0;
        int base;
        int left;
        int burst;
        code_t codes [256];
        code_t tmp;
        int j;
        dl_data_t data;
        code_t pix_codes [8];
        dl_addr_t beat_addr [32];
        dl_data_t beat_data [32];
        void'($urandom(32'h3b4c));
        reset = 1'b1;
        dl_start = 1'b0;
        dl_valid = 1'b0;
        dl_beat = '0;
        pix_valid = 1'b0;
        pix_code = '0;
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;

        // idle outputs after reset, then first accept on credit
        current_test = "after_reset";
        e0 = errors;
        repeat (16) begin
            @(posedge clk);
            if (out_valid || dl_credit || pix_credit) report_failure("output high with no stimulus");
        end
        #2;
        send_pixel(8'h00);
        repeat (10) next_cycle();
        check_value("pix_credit before out credit", 0, pix_pulses);
        grant_out_credits(1);
        wait_for_outputs();
        check_value("pix_credit after out credit", 1, pix_pulses);
        end_test(e0);

        // full download then every code once
        current_test = "full_download";
        e0 = errors;
        dl_start = 1'b1;
        for (int a = 0; a < 512; a++) begin
            data = dl_data_t'($urandom);
            load_shadow(dl_addr_t'(a), data);
            send_beat(dl_addr_t'(a), data);
        end
        dl_start = 1'b0;
        wait_for_dl_credits();
        for (int i = 0; i < 256; i++) codes[i] = code_t'(i);
        for (int i = 255; i > 0; i--) begin
            j = $urandom_range(i, 0);
            tmp = codes[i];
            codes[i] = codes[j];
            codes[j] = tmp;
        end
        grant_out_credits(256);
        for (int i = 0; i < 256; i++) send_pixel(codes[i]);
        wait_for_outputs();
        end_test(e0);

        current_test = "dl_credits";
        e0 = errors;
        check_value("dl_credit pulses", beats_sent, dl_pulses);
        end_test(e0);

        // output back pressure
        current_test = "backpressure";
        e0 = errors;
        base = out_cnt;
        fork
            for (int i = 0; i < 20; i++) send_pixel(code_t'($urandom));
            begin
                repeat (50) next_cycle();
                check_value("outputs while withheld", base, out_cnt);
                left = 20;
                while (left > 0) begin
                    burst = $urandom_range(4, 1);
                    if (burst > left) burst = left;
                    grant_out_credits(burst);
                    left -= burst;
                    repeat ($urandom_range(6, 1)) next_cycle();
                end
            end
        join
        wait_for_outputs();
        check_value("outputs vs credits", granted, out_cnt);
        end_test(e0);

        // pixels held off by a second partial download
        current_test = "second_download";
        e0 = errors;
        // rewrite the lut entries of the codes sent, then the colours they now point at
        for (int i = 0; i < 8; i++) pix_codes[i] = code_t'($urandom);
        for (int i = 0; i < 32; i++) begin
            if (i < 8) beat_addr[i] = {REGION_LUT, pix_codes[i]};
            else if (i < 16) beat_addr[i] = {REGION_COL, beat_data[i - 8]};
            else beat_addr[i] = dl_addr_t'($urandom);
            beat_data[i] = dl_data_t'($urandom);
            load_shadow(beat_addr[i], beat_data[i]);
        end
        dl_busy = 1'b1;
        dl_start = 1'b1;
        repeat (2) next_cycle();
        fork
            begin
                for (int i = 0; i < 32; i++) begin
                    send_beat(beat_addr[i], beat_data[i]);
                    repeat ($urandom_range(3, 0)) next_cycle();
                end
                dl_start = 1'b0;
                wait_for_dl_credits();
                dl_busy = 1'b0;
            end
            for (int i = 0; i < 8; i++) send_pixel(pix_codes[i]);
            grant_out_credits(8);
        join
        wait_for_outputs();
        end_test(e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
common/palette_pkg.sv
rtl/prom.sv
download/dl_ctrl.sv
rtl/pal_lookup.sv
rtl/palette_top.sv
tests/palette_top_asserts.sv
tests/tb_palette_top.sv
